// File: source/decoderPkg.sv
package decoderPkg;

    localparam int MaxMsgBits = 7;                  // longest message, size code Size7
    localparam int RxBits     = 2 * MaxMsgBits;     // one 2-bit symbol per message bit, no tail
    localparam int MetricBits = 4;                  // worst distance is 14
    localparam int PosBits    = 3;                  // holds a bit position or a length up to 7
    localparam int PairBits   = MaxMsgBits - 1;     // candidate pair index, lsb picks the lane

    localparam logic [2:0] Gen1 = 3'o7;             // upper symbol bit taps
    localparam logic [2:0] Gen2 = 3'o5;             // lower symbol bit taps

    typedef logic [MaxMsgBits-1:0] msgT;            // message or candidate, unused msbs zero
    typedef logic [RxBits-1:0]     rxT;             // symbol for bit k sits in [2k+1:2k]
    typedef logic [MetricBits-1:0] metricT;
    typedef logic [1:0]            symbolT;
    typedef logic [PosBits-1:0]    posT;
    typedef logic [PairBits-1:0]   pairT;

    typedef enum logic [1:0] {
        Size3 = 2'd0,
        Size4 = 2'd1,
        Size5 = 2'd2,
        Size7 = 2'd3
    } sizeT;

    // message length in bits for a size code
    function automatic posT msgLength(input sizeT size);
        case (size)
            Size3:   msgLength = posT'(3);
            Size4:   msgLength = posT'(4);
            Size5:   msgLength = posT'(5);
            default: msgLength = posT'(7);
        endcase
    endfunction

endpackage

// File: source/laneIf.sv
`timescale 1ns/1ps

// one bit of one candidate per cycle, sequencer to evaluator
interface laneIf import decoderPkg::*; ();

    logic   step;       // a bit is valid this cycle
    logic   first;      // first bit of the candidate, msb
    logic   last;       // last bit of the candidate, bit 0
    msgT    candidate;  // whole candidate, held over all its bits
    logic   msgBit;     // candidate bit at the current position
    symbolT symbol;     // received symbol at the same position

    modport seq (
        output step, first, last,
        output candidate, msgBit, symbol
    );

    modport eval (
        input step, first, last,
        input candidate, msgBit, symbol
    );

endinterface

// File: source/resultIf.sv
`timescale 1ns/1ps

// finished candidate from one evaluator, no handshake
interface resultIf import decoderPkg::*; ();

    logic   valid;      // one-cycle pulse per candidate
    msgT    candidate;
    metricT distance;   // hamming distance to the received word
    logic   finalPair;  // candidate belongs to the last pair of the search

    modport eval (
        output valid,
        output candidate, distance, finalPair
    );

    modport sel (
        input valid,
        input candidate, distance, finalPair
    );

endinterface

// File: source/searchSequencer.sv
`timescale 1ns/1ps

module searchSequencer import decoderPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  rxT   received,
    input  sizeT size,
    output logic busy,
    laneIf.seq   lane0,          // even candidates
    laneIf.seq   lane1,          // odd candidates
    output logic finalPair       // current pair is the last one
);

    rxT     rxHeld;              // received word captured at start
    posT    lenHeld;             // message length of this search
    pairT   pairIdx;             // candidates 2p and 2p+1 in flight
    pairT   lastPair;            // 2^(N-1) - 1
    posT    bitPos;              // runs N-1 down to 0
    logic   accept;
    logic   firstBit;
    logic   lastBit;
    msgT    candEven;
    msgT    candOdd;
    symbolT rxSymbol;

    assign accept = start && !busy;   // start while busy is dropped

    // all ones shifted down to the pair count of this length
    assign lastPair = pairT'({PairBits{1'b1}} >> (MaxMsgBits - int'(lenHeld)));

    assign firstBit = (bitPos == lenHeld - 1'b1);
    assign lastBit  = (bitPos == '0);

    assign candEven = {pairIdx, 1'b0};
    assign candOdd  = {pairIdx, 1'b1};
    assign rxSymbol = rxHeld[2*bitPos +: 2];   // symbol of message bit k

    // request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            rxHeld <= received;
        end
    end

    // pair and bit counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            lenHeld <= '0;
            pairIdx <= '0;
            bitPos  <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            lenHeld <= msgLength(size);
            pairIdx <= '0;
            bitPos  <= msgLength(size) - 1'b1;   // start at the msb
        end else if (busy) begin
            if (!lastBit) begin
                bitPos <= bitPos - 1'b1;
            end else if (pairIdx == lastPair) begin
                busy <= 1'b0;                    // last step of last pair done
            end else begin
                pairIdx <= pairIdx + 1'b1;       // next pair follows back to back
                bitPos  <= lenHeld - 1'b1;
            end
        end
    end

    assign finalPair = busy && (pairIdx == lastPair);

    // both lanes step together, only the candidate differs
    assign lane0.step      = busy;
    assign lane0.first     = busy && firstBit;
    assign lane0.last      = busy && lastBit;
    assign lane0.candidate = candEven;
    assign lane0.msgBit    = candEven[bitPos];
    assign lane0.symbol    = rxSymbol;

    assign lane1.step      = busy;
    assign lane1.first     = busy && firstBit;
    assign lane1.last      = busy && lastBit;
    assign lane1.candidate = candOdd;
    assign lane1.msgBit    = candOdd[bitPos];
    assign lane1.symbol    = rxSymbol;

endmodule

// File: source/pathEvaluator.sv
`timescale 1ns/1ps

module pathEvaluator import decoderPkg::*; (
    input  logic  clk,
    input  logic  rst,
    laneIf.eval   lane,
    resultIf.eval result,
    input  logic  finalPair
);

    logic [1:0] encState;        // previous two message bits, newest in bit 1
    logic [1:0] baseState;       // state seen by this step
    logic [2:0] window;          // current bit, then prev1, prev2
    symbolT     expected;        // code symbol of the candidate
    symbolT     diff;
    metricT     accDist;         // running distance of the current candidate
    metricT     baseDist;
    metricT     sumDist;         // distance including this step

    // a new candidate starts from state zero and distance zero
    assign baseState = lane.first ? 2'b00 : encState;
    assign baseDist  = lane.first ? '0 : accDist;

    assign window   = {lane.msgBit, baseState};
    assign expected = {^(window & Gen1), ^(window & Gen2)};   // upper from Gen1
    assign diff     = expected ^ lane.symbol;
    assign sumDist  = baseDist + metricT'(diff[1]) + metricT'(diff[0]);   // popcount

    // encoder shift and accumulate
    always_ff @(posedge clk) begin
        if (lane.step) begin
            encState <= {lane.msgBit, baseState[1]};
            accDist  <= sumDist;
        end
    end

    // hold finished candidate while the next one accumulates
    always_ff @(posedge clk) begin
        if (lane.step && lane.last) begin
            result.candidate <= lane.candidate;
            result.distance  <= sumDist;
            result.finalPair <= finalPair;
        end
    end

    // valid one cycle after the last step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= lane.step && lane.last;
        end
    end

endmodule

// File: source/pathSelector.sv
`timescale 1ns/1ps

module pathSelector import decoderPkg::*; (
    input  logic  clk,
    input  logic  rst,
    resultIf.sel  res0,          // even candidate of the pair
    resultIf.sel  res1,          // odd candidate of the pair
    output logic  done,
    output msgT   decoded,
    output metricT distance
);

    logic   fresh;               // no result yet in this search
    logic   pairValid;
    logic   pairFinal;
    logic   takeEven;
    logic   takeOdd;
    metricT bestDist;
    metricT curDist;             // best so far, max at the start of a search
    metricT evenDist;
    metricT nextDist;
    msgT    bestCand;
    msgT    evenCand;
    msgT    nextCand;

    // both lanes finish on the same cycle
    assign pairValid = res0.valid && res1.valid;
    assign pairFinal = res0.finalPair && res1.finalPair;

    // max metric is above any real distance, so the first even result always wins
    assign curDist = fresh ? '1 : bestDist;

    // strict compares keep the smaller candidate on a tie
    assign takeEven = res0.distance < curDist;
    assign evenDist = takeEven ? res0.distance : curDist;
    assign evenCand = takeEven ? res0.candidate : bestCand;

    assign takeOdd  = res1.distance < evenDist;   // beats best and even
    assign nextDist = takeOdd ? res1.distance : evenDist;
    assign nextCand = takeOdd ? res1.candidate : evenCand;

    // running best
    always_ff @(posedge clk) begin
        if (pairValid) begin
            bestDist <= nextDist;
            bestCand <= nextCand;
        end
    end

    // result registers, change only with done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fresh    <= 1'b1;
            done     <= 1'b0;
            decoded  <= '0;
            distance <= '0;
        end else begin
            done <= 1'b0;                  // single-cycle pulse
            if (pairValid) begin
                fresh <= pairFinal;        // next search starts over
                if (pairFinal) begin
                    done     <= 1'b1;
                    decoded  <= nextCand;
                    distance <= nextDist;
                end
            end
        end
    end

endmodule

// File: source/convDecoder.sv
`timescale 1ns/1ps

module convDecoder import decoderPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,        // taken only while busy is low
    input  rxT     received,
    input  sizeT   size,
    output logic   busy,
    output logic   done,         // one-cycle pulse with the result
    output msgT    decoded,
    output metricT distance
);

    logic finalPair;             // sequencer is on its last pair

    laneIf   lane0 ();           // even candidates
    laneIf   lane1 ();           // odd candidates
    resultIf res0 ();
    resultIf res1 ();

    // request capture and candidate stepping
    searchSequencer sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .received  (received),
        .size      (size),
        .busy      (busy),
        .lane0     (lane0.seq),
        .lane1     (lane1.seq),
        .finalPair (finalPair)
    );

    // candidates 2p
    pathEvaluator evalEven (
        .clk       (clk),
        .rst       (rst),
        .lane      (lane0.eval),
        .result    (res0.eval),
        .finalPair (finalPair)
    );

    // candidates 2p+1
    pathEvaluator evalOdd (
        .clk       (clk),
        .rst       (rst),
        .lane      (lane1.eval),
        .result    (res1.eval),
        .finalPair (finalPair)
    );

    // best of all pairs, raises done
    pathSelector selector (
        .clk      (clk),
        .rst      (rst),
        .res0     (res0.sel),
        .res1     (res1.sel),
        .done     (done),
        .decoded  (decoded),
        .distance (distance)
    );

endmodule

// File: testbench/convDecoderTb.sv
`timescale 1ns/1ps

module convDecoderTb import decoderPkg::*; ();

    localparam int DoneTimeout = 1000;      // in cycles and well above 64 pairs of 7 bits

    logic   clk;
    logic   rst;
    logic   start;
    rxT     received;
    sizeT   size;
    logic   busy;
    logic   done;
    msgT    decoded;
    metricT distance;

    logic [31:0] rngState;                  // xorshift state

    convDecoder convDecoder_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .received (received),
        .size     (size),
        .busy     (busy),
        .done     (done),
        .decoded  (decoded),
        .distance (distance)
    );

    always #10 clk = ~clk;                  // 20 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    // message length for a size code
    function automatic int sizeBits(input sizeT s);
        case (s)
            Size3:   return 3;
            Size4:   return 4;
            Size5:   return 5;
            default: return 7;
        endcase
    endfunction

    // reference encoder from state zero with the msb first
    function automatic rxT encodeMsg(input msgT msg, input int n);
        rxT   word;
        logic cur;
        logic prev1;
        logic prev2;
        int   k;
        word  = '0;
        prev1 = 1'b0;
        prev2 = 1'b0;
        for (k = n - 1; k >= 0; k--) begin
            cur = msg[k];
            word[2*k+1] = (Gen1[2] & cur) ^ (Gen1[1] & prev1) ^ (Gen1[0] & prev2);
            word[2*k]   = (Gen2[2] & cur) ^ (Gen2[1] & prev1) ^ (Gen2[0] & prev2);
            prev2 = prev1;
            prev1 = cur;
        end
        return word;
    endfunction

    // only the low 2n bits count
    function automatic int hamming(input rxT a, input rxT b, input int n);
        int count;
        int i;
        count = 0;
        for (i = 0; i < 2 * n; i++) begin
            if (a[i] != b[i]) begin
                count++;
            end
        end
        return count;
    endfunction

    // brute force in ascending order where only a strictly lower distance wins
    task automatic bestMatch(input rxT rx, input int n, output int best, output int bestDist);
        int cand;
        int d;
        best     = 0;
        bestDist = 2 * MaxMsgBits + 1;     // above any real distance
        for (cand = 0; cand < (1 << n); cand++) begin
            d = hamming(encodeMsg(msgT'(cand), n), rx, n);
            if (d < bestDist) begin
                bestDist = d;
                best     = cand;
            end
        end
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // runs from a falling edge to the falling edge that sees done
    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == DoneTimeout) begin
                $display("done never came within %0d cycles of the start", DoneTimeout);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout waiting for done");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // results hold and no extra done comes while idle
    task automatic holdIdle(input int cycles, input int expMsg, input int expDist);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            checkValue("done", 0, int'(done));
            checkValue("busy", 0, int'(busy));
            checkValue("decoded", expMsg, int'(decoded));
            checkValue("distance", expDist, int'(distance));
        end
    endtask

    // one request from a falling edge to its result
    task automatic decodeAndCheck(input rxT rx, input sizeT sz, input int expMsg,
                                  input int expDist);
        logic [31:0] r;
        start    = 1'b1;
        received = rx;
        size     = sz;
        @(negedge clk);
        start = 1'b0;
        nextRandom(r);
        received = rxT'(r);                 // word must already be latched
        size     = sizeT'(r[31:30]);
        checkValue("busy", 1, int'(busy));
        waitDone();
        checkValue("decoded", expMsg, int'(decoded));
        checkValue("distance", expDist, int'(distance));
        checkValue("busy", 0, int'(busy));
        nextRandom(r);
        holdIdle(1 + int'(r % 4), expMsg, expDist);
    endtask

    initial begin
        logic [31:0] r;
        sizeT        sz;
        msgT         msg;
        rxT          word;
        int          n;
        int          s;
        int          rep;
        int          flips;
        int          f;
        int          pos;
        int          expMsg;
        int          expDist;

        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        received = '0;
        size     = Size3;
        rngState = 32'h44f9e91c;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("busy", 0, int'(busy));
        checkValue("done", 0, int'(done));
        checkValue("decoded", 0, int'(decoded));
        checkValue("distance", 0, int'(distance));

        // clean codewords decode to the message at distance zero
        for (s = 0; s < 4; s++) begin
            for (rep = 0; rep < 6; rep++) begin
                sz = sizeT'(s);
                n  = sizeBits(sz);
                nextRandom(r);
                msg  = msgT'(r & ((1 << n) - 1));
                word = encodeMsg(msg, n);
                decodeAndCheck(word, sz, int'(msg), 0);
            end
        end

        // one to three flipped bits inside the codeword
        for (s = 0; s < 4; s++) begin
            for (rep = 0; rep < 8; rep++) begin
                sz = sizeT'(s);
                n  = sizeBits(sz);
                nextRandom(r);
                msg  = msgT'(r & ((1 << n) - 1));
                word = encodeMsg(msg, n);
                nextRandom(r);
                flips = 1 + int'(r % 3);
                for (f = 0; f < flips; f++) begin
                    nextRandom(r);
                    pos = int'(r % (2 * n));
                    word[pos] = ~word[pos];
                end
                bestMatch(word, n, expMsg, expDist);
                decodeAndCheck(word, sz, expMsg, expDist);
            end
        end

        // fully random words with junk above bit 2N
        for (rep = 0; rep < 40; rep++) begin
            nextRandom(r);
            sz = sizeT'(r[1:0]);
            n  = sizeBits(sz);
            nextRandom(r);
            word = rxT'(r);
            bestMatch(word, n, expMsg, expDist);
            decodeAndCheck(word, sz, expMsg, expDist);
        end

        // start held high while busy must not restart the search
        nextRandom(r);
        word = rxT'(r);
        bestMatch(word, 7, expMsg, expDist);
        start    = 1'b1;
        received = word;
        size     = Size7;
        @(negedge clk);
        checkValue("busy", 1, int'(busy));
        for (rep = 0; rep < 3; rep++) begin
            nextRandom(r);
            received = rxT'(r);             // shorter competing request
            size     = Size3;
            @(negedge clk);
        end
        start = 1'b0;
        waitDone();
        checkValue("decoded", expMsg, int'(decoded));
        checkValue("distance", expDist, int'(distance));
        holdIdle(40, expMsg, expDist);      // no second done and busy stays low

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: list.f
source/decoderPkg.sv
source/laneIf.sv
source/resultIf.sv
source/searchSequencer.sv
source/pathEvaluator.sv
source/pathSelector.sv
source/convDecoder.sv
testbench/convDecoderTb.sv

// File: Makefile
# Verilator build and run of the convolutional decoder testbench

BIN  := obj_dir/VconvDecoderTb
SRCS := $(wildcard source/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module convDecoderTb -f list.f

# exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
